// ==== src.f ====
+incdir+rtl
+incdir+tb
rtl/cpu_pkg.sv
rtl/alu.sv
rtl/step_counter.sv
rtl/cpu_sequencer.sv
rtl/cpu_datapath.sv
rtl/cpu_top.sv
tb/tb_cpu.sv

// ==== Bender.yml ====
package:
  name: cpu_m2m

export_include_dirs:
  - rtl

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/cpu_pkg.sv
      - rtl/alu.sv
      - rtl/step_counter.sv
      - rtl/cpu_sequencer.sv
      - rtl/cpu_datapath.sv
      - rtl/cpu_top.sv
  - target: simulation
    include_dirs:
      - rtl
      - tb
    files:
      - tb/tb_cpu.sv

// ==== tb/cpu_tests.svh ====
`ifndef CPU_TESTS_SVH
`define CPU_TESTS_SVH

function automatic logic [5:0] operand_dest(input logic [3:0] f);
    // in indirect mode the low six bits of the cell point to the word
    if (f[3]) begin
        return model[f[2:0]][5:0];
    end
    return {3'b000, f[2:0]};
endfunction

function automatic logic [15:0] operand_value(input logic [3:0] f);
    return model[operand_dest(f)];
endfunction

task automatic expect_out(input logic [15:0] v);
    // out only logs changes
    if (v !== last_exp_out) begin
        exp_out.push_back(v);
    end
    last_exp_out = v;
endtask

// place one instruction and apply it to the expected image
task automatic add_instr(input opcode_t op, input logic [3:0] x, input logic [3:0] y,
                         input logic [3:0] z);
    logic [15:0] vy;
    logic [15:0] vz;
    logic [15:0] res;
    logic        wr;
    put_word(prog_ptr, {op, x, y, z});
    prog_ptr++;
    n_instr++;
    vy  = operand_value(y);
    vz  = operand_value(z);
    wr  = 1'b1;
    res = '0;
    case (op)
        op_mov: res = vy;
        op_add: res = vy + vz;
        op_sub: res = vy - vz;
        op_mul: res = vy * vz;
        op_div: res = (vz == 16'h0) ? 16'h0 : vy / vz;
        op_in:  res = in_port;
        op_out: begin
            wr = 1'b0;
            expect_out(operand_value(x));
        end
        default: begin
            wr = 1'b0;
            if (x[2:0] != 3'd0) expect_out(operand_value(x));
            if (y[2:0] != 3'd0) expect_out(vy);
            if (z[2:0] != 3'd0) expect_out(vz);
        end
    endcase
    if (wr) begin
        model[operand_dest(x)] = res;
    end
endtask

task automatic test_reset_boot();
    begin_test("reset_boot");
    add_instr(op_stop, 4'h0, 4'h0, 4'h0);
    @(posedge clk);
    #1;
    if (we !== 1'b0) report_mismatch("we", 16'(we), 16'h0);
    if (status !== 1'b0) report_mismatch("status", 16'(status), 16'h0);
    if (out !== 16'h0) report_mismatch("out", out, 16'h0);
    if (pc !== 6'h0) report_mismatch("pc", 16'(pc), 16'h0);
    release_reset();
    for (int i = 0; i < 4 && pc !== `CPU_PROG_START; i++) begin
        @(posedge clk);
        #1;
    end
    if (pc !== `CPU_PROG_START) report_problem("pc never reached the program start");
    if (write_count != 0) report_problem("memory was written before boot finished");
    run_to_halt();
    check_results();
endtask

task automatic test_mov();
    begin_test("mov");
    put_word(1, rand_word(16));
    put_word(2, pointer_word(6'd40));
    put_word(3, pointer_word(6'd41));
    put_word(41, rand_word(16));
    add_instr(op_mov, 4'h5, 4'h1, 4'h0);
    add_instr(op_mov, 4'ha, 4'hb, 4'h0);
    add_instr(op_mov, 4'h6, 4'hb, 4'h0);
    add_instr(op_stop, 4'h0, 4'h0, 4'h0);
    release_reset();
    run_to_halt();
    check_results();
endtask

task automatic test_arith();
    begin_test("arith");
    put_word(0, 16'h0);
    put_word(1, rand_word(16));
    put_word(2, rand_word(8) | 16'h1);
    put_word(5, pointer_word(6'd42));
    put_word(6, pointer_word(6'd43));
    put_word(7, pointer_word(6'd44));
    put_word(43, rand_word(16));
    add_instr(op_add, 4'h4, 4'h1, 4'h2);
    add_instr(op_sub, 4'hd, 4'h1, 4'he);
    add_instr(op_mul, 4'hf, 4'he, 4'h2);
    add_instr(op_div, 4'h3, 4'h1, 4'h2);
    // cell 0 holds zero
    add_instr(op_div, 4'h4, 4'h1, 4'h0);
    add_instr(op_stop, 4'h0, 4'h0, 4'h0);
    release_reset();
    run_to_halt();
    if (memory[4] !== 16'h0) report_mismatch("mem[4] after divide by zero", memory[4], 16'h0);
    check_results();
endtask

task automatic test_in_out();
    begin_test("in_out");
    in_port = rand_word(16);
    put_word(1, rand_word(16));
    put_word(5, pointer_word(6'd42));
    put_word(6, pointer_word(6'd43));
    put_word(43, rand_word(16));
    add_instr(op_in, 4'h3, 4'h0, 4'h0);
    add_instr(op_in, 4'hd, 4'h0, 4'h0);
    add_instr(op_out, 4'h1, 4'h0, 4'h0);
    add_instr(op_out, 4'he, 4'h0, 4'h0);
    add_instr(op_stop, 4'h0, 4'h0, 4'h0);
    release_reset();
    run_to_halt();
    check_results();
endtask

task automatic test_stop();
    logic [5:0] halt_pc;
    int         halt_writes;
    begin_test("stop");
    // nonzero value in cell 0 that is still skipped by number
    put_word(0, rand_word(16));
    put_word(2, pointer_word(6'd40));
    put_word(3, rand_word(16));
    put_word(40, rand_word(16));
    add_instr(op_mov, 4'h4, 4'h3, 4'h0);
    add_instr(op_stop, 4'ha, 4'h0, 4'h4);
    release_reset();
    run_to_halt();
    halt_pc     = pc;
    halt_writes = write_count;
    repeat (20) @(posedge clk);
    #1;
    if (status !== 1'b1) report_mismatch("status", 16'(status), 16'h1);
    if (pc !== halt_pc) report_mismatch("pc", 16'(pc), 16'(halt_pc));
    if (write_count != halt_writes) report_problem("memory was written after the halt");
    check_results();
endtask

`endif

// ==== tb/tb_cpu.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "cpu_consts.svh"

module tb_cpu
    import cpu_pkg::*;
();

    localparam int clk_period   = 4;
    localparam int reset_cycles = 5;
    localparam int mem_words    = 64;
    localparam int n_tests      = 5;
    // instructions in all tests including the STOP words
    localparam int total_instrs = 18;
    localparam int wd_cycles    = 40 * total_instrs + n_tests * (reset_cycles + 30);

    logic                       clk;
    logic                       rst_n;
    logic [`CPU_DATA_WIDTH-1:0] mem_rd;
    logic [`CPU_DATA_WIDTH-1:0] in_port;
    logic                       we;
    logic [`CPU_ADDR_WIDTH-1:0] addr;
    logic [`CPU_DATA_WIDTH-1:0] data;
    logic [`CPU_DATA_WIDTH-1:0] out;
    logic [`CPU_ADDR_WIDTH-1:0] pc;
    logic                       status;

    // memory seen by the DUT and the expected image
    logic [15:0] memory [mem_words];
    logic [15:0] model [mem_words];

    logic [15:0] out_log [$];
    logic [15:0] exp_out [$];
    logic [15:0] last_out;
    logic [15:0] last_exp_out;
    logic [15:0] lfsr_state;
    logic [5:0]  prog_ptr;
    int          n_instr;
    int          write_count  = 0;
    int          error_count  = 0;
    int          test_errs    = 0;
    int          tests_run    = 0;
    int          tests_failed = 0;
    string       test_name;

    cpu_top cpu_top_i (
        .clk    (clk),
        .rst_n  (rst_n),
        .mem    (mem_rd),
        .in     (in_port),
        .we     (we),
        .addr   (addr),
        .data   (data),
        .out    (out),
        .pc     (pc),
        .status (status)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    // synchronous memory with read data one cycle after addr
    always @(posedge clk) begin
        if (we) begin
            memory[addr] <= data;
        end
        mem_rd <= #1 memory[addr];
    end

    // count writes and log every change of out
    always @(negedge clk) begin
        if (rst_n) begin
            if (we) begin
                write_count++;
            end
            if (out !== last_out) begin
                out_log.push_back(out);
                last_out = out;
            end
        end
    end

    initial begin
        #(wd_cycles * clk_period);
        $display("watchdog expired after %0d cycles, the tests did not complete", wd_cycles);
        $display("Errors found");
        $finish;
    end

    // taps x^16 + x^14 + x^13 + x^11 + 1 stepped once per bit
    function automatic logic [15:0] rand_word(input int nbits);
        logic [15:0] w;
        logic        fb;
        w = '0;
        for (int i = 0; i < nbits; i++) begin
            fb         = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
            lfsr_state = {lfsr_state[14:0], fb};
            w          = {w[14:0], fb};
        end
        return w;
    endfunction

    // random upper bits above the six-bit target address
    function automatic logic [15:0] pointer_word(input logic [5:0] p);
        logic [15:0] r;
        r = rand_word(10);
        return {r[9:0], p};
    endfunction

    function automatic logic [15:0] fill_word(input int a);
        return 16'(a * 16'h0409) ^ 16'hc3a5;
    endfunction

    task automatic report_mismatch(input string sig, input logic [15:0] got,
                                   input logic [15:0] expected);
        $display("FAIL %s: %s got %h expected %h", test_name, sig, got, expected);
        error_count++;
        test_errs++;
    endtask

    task automatic report_problem(input string msg);
        $display("test %s: %s", test_name, msg);
        error_count++;
        test_errs++;
    endtask

    task automatic put_word(input int a, input logic [15:0] v);
        memory[a] = v;
        model[a]  = v;
    endtask

    task automatic begin_test(input string name);
        @(posedge clk);
        #1;
        rst_n     = 1'b0;
        test_name = name;
        test_errs = 0;
        prog_ptr  = `CPU_PROG_START;
        n_instr   = 0;
        exp_out.delete();
        last_exp_out = '0;
        for (int a = 0; a < mem_words; a++) begin
            put_word(a, fill_word(a));
        end
    endtask

    task automatic release_reset();
        repeat (reset_cycles) @(posedge clk);
        #1;
        out_log.delete();
        last_out    = '0;
        write_count = 0;
        rst_n       = 1'b1;
    endtask

    task automatic run_to_halt();
        int limit;
        int cycles;
        limit  = 40 * n_instr;
        cycles = 0;
        while (status !== 1'b1 && cycles < limit) begin
            @(posedge clk);
            #1;
            cycles++;
        end
        if (status !== 1'b1) begin
            report_problem($sformatf("status did not rise within %0d cycles", limit));
        end
    endtask

    task automatic check_results();
        for (int a = 0; a < mem_words; a++) begin
            if (memory[a] !== model[a]) begin
                report_mismatch($sformatf("mem[%0d]", a), memory[a], model[a]);
            end
        end
        if (out_log.size() != exp_out.size()) begin
            report_mismatch("out change count", 16'(out_log.size()), 16'(exp_out.size()));
        end else begin
            foreach (out_log[i]) begin
                if (out_log[i] !== exp_out[i]) begin
                    report_mismatch($sformatf("out change %0d", i), out_log[i], exp_out[i]);
                end
            end
        end
        tests_run++;
        if (test_errs == 0) begin
            $display("test %s passed", test_name);
        end else begin
            tests_failed++;
            $display("test %s failed with %0d mismatches", test_name, test_errs);
        end
    endtask

    `include "cpu_tests.svh"

    initial begin
        rst_n      = 1'b0;
        in_port    = '0;
        mem_rd     = '0;
        lfsr_state = 16'd58762;
        test_reset_boot();
        test_mov();
        test_arith();
        test_in_out();
        test_stop();
        $display("tests run %0d, tests failed %0d, mismatches %0d",
                 tests_run, tests_failed, error_count);
        if (error_count == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== rtl/cpu_top.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "cpu_consts.svh"

module cpu_top
    import cpu_pkg::*;
(
    input  wire                        clk,
    input  wire                        rst_n,
    input  wire  [`CPU_DATA_WIDTH-1:0] mem,
    input  wire  [`CPU_DATA_WIDTH-1:0] in,
    output logic                       we,
    output logic [`CPU_ADDR_WIDTH-1:0] addr,
    output logic [`CPU_DATA_WIDTH-1:0] data,
    output logic [`CPU_DATA_WIDTH-1:0] out,
    output logic [`CPU_ADDR_WIDTH-1:0] pc,
    output logic                       status
);

    logic [`CPU_STEP_WIDTH-1:0] step;
    logic [`CPU_STEP_WIDTH-1:0] step_target;
    logic step_adv;
    logic step_jump;
    logic step_clr;
    logic pc_init;
    logic pc_inc;
    logic mar_from_pc;
    logic mar_from_base;
    logic mar_from_ptr;
    logic mar_from_dest;
    logic mdr_ld;
    logic ir_ld;
    logic opnd_ld;
    logic [1:0] opnd_idx;
    logic a_from_y;
    logic a_from_in;
    logic a_from_alu;
    logic r_ld;
    logic [`CPU_DATA_WIDTH-1:0] ir;
    logic [`CPU_DATA_WIDTH-1:0] y_val;
    logic [`CPU_DATA_WIDTH-1:0] z_val;
    logic [`CPU_DATA_WIDTH-1:0] alu_f;
    opcode_t opcode;

    cpu_sequencer sequencer_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .step          (step),
        .ir            (ir),
        .step_adv      (step_adv),
        .step_jump     (step_jump),
        .step_target   (step_target),
        .step_clr      (step_clr),
        .pc_init       (pc_init),
        .pc_inc        (pc_inc),
        .mar_from_pc   (mar_from_pc),
        .mar_from_base (mar_from_base),
        .mar_from_ptr  (mar_from_ptr),
        .mar_from_dest (mar_from_dest),
        .mdr_ld        (mdr_ld),
        .ir_ld         (ir_ld),
        .opnd_ld       (opnd_ld),
        .opnd_idx      (opnd_idx),
        .a_from_y      (a_from_y),
        .a_from_in     (a_from_in),
        .a_from_alu    (a_from_alu),
        .r_ld          (r_ld),
        .we            (we),
        .status        (status)
    );

    step_counter step_counter_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .step_adv    (step_adv),
        .step_jump   (step_jump),
        .step_clr    (step_clr),
        .step_target (step_target),
        .step        (step)
    );

    cpu_datapath datapath_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .mem           (mem),
        .in            (in),
        .alu_f         (alu_f),
        .pc_init       (pc_init),
        .pc_inc        (pc_inc),
        .mar_from_pc   (mar_from_pc),
        .mar_from_base (mar_from_base),
        .mar_from_ptr  (mar_from_ptr),
        .mar_from_dest (mar_from_dest),
        .mdr_ld        (mdr_ld),
        .ir_ld         (ir_ld),
        .opnd_ld       (opnd_ld),
        .opnd_idx      (opnd_idx),
        .a_from_y      (a_from_y),
        .a_from_in     (a_from_in),
        .a_from_alu    (a_from_alu),
        .r_ld          (r_ld),
        .we            (we),
        .ir            (ir),
        .y_val         (y_val),
        .z_val         (z_val),
        .opcode        (opcode),
        .addr          (addr),
        .data_out      (data),
        .out           (out),
        .pc            (pc)
    );

    alu alu_i (
        .opcode (opcode),
        .a      (y_val),
        .b      (z_val),
        .f      (alu_f)
    );

endmodule

`default_nettype wire

// ==== rtl/cpu_datapath.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "cpu_consts.svh"

module cpu_datapath
    import cpu_pkg::*;
(
    input  wire                        clk,
    input  wire                        rst_n,
    input  wire  [`CPU_DATA_WIDTH-1:0] mem,
    input  wire  [`CPU_DATA_WIDTH-1:0] in,
    input  wire  [`CPU_DATA_WIDTH-1:0] alu_f,
    input  wire                        pc_init,
    input  wire                        pc_inc,
    input  wire                        mar_from_pc,
    input  wire                        mar_from_base,
    input  wire                        mar_from_ptr,
    input  wire                        mar_from_dest,
    input  wire                        mdr_ld,
    input  wire                        ir_ld,
    input  wire                        opnd_ld,
    input  wire  [1:0]                 opnd_idx,
    input  wire                        a_from_y,
    input  wire                        a_from_in,
    input  wire                        a_from_alu,
    input  wire                        r_ld,
    input  wire                        we,
    output logic [`CPU_DATA_WIDTH-1:0] ir,
    output logic [`CPU_DATA_WIDTH-1:0] y_val,
    output logic [`CPU_DATA_WIDTH-1:0] z_val,
    output opcode_t                    opcode,
    output logic [`CPU_ADDR_WIDTH-1:0] addr,
    output logic [`CPU_DATA_WIDTH-1:0] data_out,
    output logic [`CPU_DATA_WIDTH-1:0] out,
    output logic [`CPU_ADDR_WIDTH-1:0] pc
);

    localparam logic [`CPU_ADDR_WIDTH-1:0] prog_start = `CPU_PROG_START;

    logic [`CPU_DATA_WIDTH-1:0] mdr;
    logic [`CPU_DATA_WIDTH-1:0] a_reg;
    logic [`CPU_DATA_WIDTH-1:0] opnd [3];
    logic [`CPU_ADDR_WIDTH-1:0] dest [3];
    logic [`CPU_REG_BITS-1:0]   base_reg;
    logic [`CPU_ADDR_WIDTH-1:0] base_addr;

    // register cell named by the selected operand field
    always_comb begin
        case (opnd_idx)
            2'd0:    base_reg = ir[8 +: `CPU_REG_BITS];
            2'd1:    base_reg = ir[4 +: `CPU_REG_BITS];
            default: base_reg = ir[0 +: `CPU_REG_BITS];
        endcase
    end

    assign base_addr = {{(`CPU_ADDR_WIDTH-`CPU_REG_BITS){1'b0}}, base_reg};

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc   <= '0;
            addr <= '0;
            ir   <= '0;
            out  <= '0;
        end else begin
            if (pc_init) begin
                pc <= prog_start;
            end else if (pc_inc) begin
                pc <= pc + 1'b1;
            end
            // MAR sources
            if (mar_from_pc) begin
                addr <= pc;
            end else if (mar_from_base) begin
                addr <= base_addr;
            end else if (mar_from_ptr) begin
                addr <= mdr[`CPU_ADDR_WIDTH-1:0];
            end else if (mar_from_dest) begin
                addr <= dest[0];
            end
            if (ir_ld) begin
                ir <= mdr;
            end
            if (r_ld) begin
                out <= opnd[opnd_idx];
            end
        end
    end

    // operand values and where each one came from
    always_ff @(posedge clk) begin
        if (mdr_ld) begin
            mdr <= mem;
        end
        if (opnd_ld) begin
            opnd[opnd_idx] <= mdr;
        end
        if (mar_from_base) begin
            dest[opnd_idx] <= base_addr;
        end else if (mar_from_ptr) begin
            dest[opnd_idx] <= mdr[`CPU_ADDR_WIDTH-1:0];
        end
        if (a_from_y) begin
            a_reg <= opnd[1];
        end else if (a_from_in) begin
            a_reg <= in;
        end else if (a_from_alu) begin
            a_reg <= alu_f;
        end
    end

    assign y_val    = opnd[1];
    assign z_val    = opnd[2];
    assign opcode   = opcode_t'(ir[`CPU_DATA_WIDTH-1 -: 4]);
    // bus is quiet except during the write pulse
    assign data_out = we ? a_reg : '0;

endmodule

`default_nettype wire

// ==== rtl/cpu_sequencer.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "cpu_consts.svh"

module cpu_sequencer
    import cpu_pkg::*;
(
    input  wire                        clk,
    input  wire                        rst_n,
    input  wire  [`CPU_STEP_WIDTH-1:0] step,
    input  wire  [`CPU_DATA_WIDTH-1:0] ir,
    output logic                       step_adv,
    output logic                       step_jump,
    output logic [`CPU_STEP_WIDTH-1:0] step_target,
    output logic                       step_clr,
    output logic                       pc_init,
    output logic                       pc_inc,
    output logic                       mar_from_pc,
    output logic                       mar_from_base,
    output logic                       mar_from_ptr,
    output logic                       mar_from_dest,
    output logic                       mdr_ld,
    output logic                       ir_ld,
    output logic                       opnd_ld,
    output logic [1:0]                 opnd_idx,
    output logic                       a_from_y,
    output logic                       a_from_in,
    output logic                       a_from_alu,
    output logic                       r_ld,
    output logic                       we,
    output logic                       status
);

    typedef logic [`CPU_STEP_WIDTH-1:0] step_t;

    // each operand owns nine steps of the operand phase
    localparam step_t y_base    = step_t'(9);
    localparam step_t z_base    = step_t'(18);
    localparam step_t done_step = step_t'(27);

    phase_t  phase;
    phase_t  phase_next;
    opcode_t opc;
    logic    writes_back;
    logic [2:0] use_mask;
    logic [2:0] ind;
    logic [2:0] reg_nz;
    logic [1:0] idx;
    step_t   base_step;
    step_t   sub_step;

    // instruction decode, bit i belongs to operand i (x, y, z)
    assign opc    = opcode_t'(ir[`CPU_DATA_WIDTH-1 -: 4]);
    assign ind    = {ir[3], ir[7], ir[11]};
    assign reg_nz = {|ir[0 +: `CPU_REG_BITS], |ir[4 +: `CPU_REG_BITS],
                     |ir[8 +: `CPU_REG_BITS]};

    always_comb begin
        case (opc)
            op_mov:                                   use_mask = 3'b011;
            op_add, op_sub, op_mul, op_div, op_stop:  use_mask = 3'b111;
            op_in, op_out:                            use_mask = 3'b001;
            default:                                  use_mask = 3'b000;
        endcase
    end

    assign writes_back = (opc == op_mov) || (opc == op_in) || (opc == op_add) ||
                         (opc == op_sub) || (opc == op_mul) || (opc == op_div);

    // which operand the operand phase is working on
    always_comb begin
        if (step >= z_base) begin
            idx       = 2'd2;
            base_step = z_base;
        end else if (step >= y_base) begin
            idx       = 2'd1;
            base_step = y_base;
        end else begin
            idx       = 2'd0;
            base_step = '0;
        end
    end

    assign sub_step = step - base_step;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            phase <= ph_boot;
        end else begin
            phase <= phase_next;
        end
    end

    // parked for good once halted
    assign status = (phase == ph_halt);

    always_comb begin
        phase_next    = phase;
        step_adv      = 1'b0;
        step_jump     = 1'b0;
        step_target   = '0;
        step_clr      = 1'b0;
        pc_init       = 1'b0;
        pc_inc        = 1'b0;
        mar_from_pc   = 1'b0;
        mar_from_base = 1'b0;
        mar_from_ptr  = 1'b0;
        mar_from_dest = 1'b0;
        mdr_ld        = 1'b0;
        ir_ld         = 1'b0;
        opnd_ld       = 1'b0;
        opnd_idx      = 2'd0;
        a_from_y      = 1'b0;
        a_from_in     = 1'b0;
        a_from_alu    = 1'b0;
        r_ld          = 1'b0;
        we            = 1'b0;

        case (phase)
            ph_boot: begin
                pc_init    = 1'b1;
                step_clr   = 1'b1;
                phase_next = ph_fetch;
            end

            // steps 1 and 2 are issue and bubble
            ph_fetch: begin
                step_adv = 1'b1;
                case (step)
                    0: mar_from_pc = 1'b1;
                    3: mdr_ld = 1'b1;
                    4: begin
                        ir_ld  = 1'b1;
                        pc_inc = 1'b1;
                    end
                    5: begin
                        step_clr   = 1'b1;
                        phase_next = ph_operand;
                    end
                    default: ;
                endcase
            end

            ph_operand: begin
                step_adv = 1'b1;
                opnd_idx = idx;
                if (step == done_step) begin
                    step_clr   = 1'b1;
                    phase_next = ph_execute;
                end else begin
                    case (sub_step)
                        0: begin
                            if (use_mask[idx]) begin
                                mar_from_base = 1'b1;
                            end else begin
                                // unused operand, go straight to the next one
                                step_jump   = 1'b1;
                                step_target = base_step + y_base;
                            end
                        end
                        3, 7: mdr_ld = 1'b1;
                        4: begin
                            if (ind[idx]) begin
                                mar_from_ptr = 1'b1;
                            end else begin
                                opnd_ld     = 1'b1;
                                step_jump   = 1'b1;
                                step_target = base_step + y_base;
                            end
                        end
                        // pointer target captured
                        8: opnd_ld = 1'b1;
                        default: ;
                    endcase
                end
            end

            ph_execute: begin
                step_adv = 1'b1;
                if (opc == op_stop) begin
                    // show x, y, z on out, skipping cell 0
                    case (step)
                        0, 1, 2: begin
                            opnd_idx = step[1:0];
                            r_ld     = reg_nz[step[1:0]];
                        end
                        3: begin
                            step_clr   = 1'b1;
                            phase_next = ph_halt;
                        end
                        default: ;
                    endcase
                end else begin
                    case (step)
                        0: begin
                            case (opc)
                                op_mov:                         a_from_y = 1'b1;
                                op_in:                          a_from_in = 1'b1;
                                op_add, op_sub, op_mul, op_div: a_from_alu = 1'b1;
                                op_out:                         r_ld = 1'b1;
                                default: ;
                            endcase
                            mar_from_dest = writes_back;
                        end
                        1: we = writes_back;
                        3: begin
                            step_clr   = 1'b1;
                            phase_next = ph_fetch;
                        end
                        default: ;
                    endcase
                end
            end

            default: ;
        endcase
    end

endmodule

`default_nettype wire

// ==== rtl/step_counter.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "cpu_consts.svh"

module step_counter (
    input  wire                        clk,
    input  wire                        rst_n,
    input  wire                        step_adv,
    input  wire                        step_jump,
    input  wire                        step_clr,
    input  wire  [`CPU_STEP_WIDTH-1:0] step_target,
    output logic [`CPU_STEP_WIDTH-1:0] step
);

    // clear wins over jump, jump wins over advance
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            step <= '0;
        end else if (step_clr) begin
            step <= '0;
        end else if (step_jump) begin
            step <= step_target;
        end else if (step_adv) begin
            step <= step + 1'b1;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/alu.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "cpu_consts.svh"

module alu
    import cpu_pkg::*;
(
    input  wire opcode_t                   opcode,
    input  wire        [`CPU_DATA_WIDTH-1:0] a,
    input  wire        [`CPU_DATA_WIDTH-1:0] b,
    output logic       [`CPU_DATA_WIDTH-1:0] f
);

    always_comb begin
        case (opcode)
            op_add: f = a + b;
            op_sub: f = a - b;
            // low half of the product
            op_mul: f = a * b;
            op_div: begin
                // zero divisor gives zero
                if (b == '0) begin
                    f = '0;
                end else begin
                    f = a / b;
                end
            end
            default: f = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== rtl/cpu_pkg.sv ====
`default_nettype none

package cpu_pkg;

    // top-level machine phase
    typedef enum logic [2:0] {
        ph_boot    = 3'd0,
        ph_fetch   = 3'd1,
        ph_operand = 3'd2,
        ph_execute = 3'd3,
        ph_halt    = 3'd4
    } phase_t;

    // instruction opcode in bits 15:12
    typedef enum logic [3:0] {
        op_mov  = 4'h0,
        op_add  = 4'h1,
        op_sub  = 4'h2,
        op_mul  = 4'h3,
        op_div  = 4'h4,
        op_in   = 4'h7,
        op_out  = 4'h8,
        op_stop = 4'hf
    } opcode_t;

endpackage

`default_nettype wire

// ==== rtl/cpu_consts.svh ====
`ifndef CPU_CONSTS_SVH
`define CPU_CONSTS_SVH

// memory bus widths
`define CPU_ADDR_WIDTH 6
`define CPU_DATA_WIDTH 16

// first program word, just above the register cells
`define CPU_PROG_START 8

// register cell number inside an operand field
`define CPU_REG_BITS 3

// micro-step counter width, enough for the 28-step operand phase
`define CPU_STEP_WIDTH 5

`endif
